//--- design/core_cfg_pkg.sv
package core_cfg_pkg;

    // Fetch and issue lanes
    localparam int DECODER_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;

    // Issue queue shape, depth is a power of two so the pointers wrap on their own
    localparam int IQ_DEPTH = 8;
    localparam int IQ_PTR_W = 3;

    // Legal fetch window
    localparam logic [31:0] FETCH_LO = 32'h1c00_0000;
    localparam logic [31:0] FETCH_HI = 32'h1fff_ffff;

endpackage

//--- design/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] bus32_t;

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_BRU = 2'd1,
        UNIT_LSU = 2'd2
    } unit_t;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_LUI = 4'd5,
        OP_LD  = 4'd6,
        OP_ST  = 4'd7,
        OP_BEQ = 4'd8,
        OP_BNE = 4'd9,
        OP_B   = 4'd10,
        OP_BL  = 4'd11
    } op_t;

    // Fetch address error and invalid instruction
    typedef struct packed {
        logic adef;
        logic ine;
    } exc_t;

    // One decoded instruction, 128 bits
    typedef struct packed {
        bus32_t     pc;
        unit_t      unit;
        op_t        op;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        bus32_t     imm;
        logic       reg_write;
        logic       pre_taken;
        bus32_t     pre_addr;
        exc_t       exc;
        logic [6:0] rsvd;
    } id_dispatch_t;

endpackage

//--- design/iq_if.sv
interface iq_if
    import core_cfg_pkg::*;
    import decode_pkg::*;
();

    // Enqueue side, entry 0 is the older one
    logic         [DECODER_WIDTH-1:0] enq_en;
    id_dispatch_t [DECODER_WIDTH-1:0] enq_data;

    // Dequeue side, deq_data[0] is the head
    logic         [ISSUE_WIDTH-1:0] deq_en;
    id_dispatch_t [ISSUE_WIDTH-1:0] deq_data;

    logic [IQ_PTR_W:0] count;
    logic              full;

    modport producer (output enq_en, output enq_data, input full);

    modport buffer (
        input  enq_en, enq_data, deq_en,
        output deq_data, count, full
    );

    modport consumer (output deq_en, input deq_data, input count);

endinterface

//--- design/inst_decoder.sv
module inst_decoder
    import core_cfg_pkg::*;
    import decode_pkg::*;
(
    input  bus32_t       pc_i,
    input  bus32_t       inst_i,
    input  logic         pre_taken_i,
    input  bus32_t       pre_addr_i,
    output id_dispatch_t rec_o
);

    logic [4:0] rd_f;
    logic [4:0] rj_f;
    logic [4:0] rk_f;
    bus32_t si12;
    bus32_t ui12;
    bus32_t si20;
    bus32_t offs16;
    bus32_t offs26;
    id_dispatch_t dec;
    logic hit;
    logic adef;

    assign rd_f = inst_i[4:0];
    assign rj_f = inst_i[9:5];
    assign rk_f = inst_i[14:10];

    assign si12   = {{20{inst_i[21]}}, inst_i[21:10]};
    assign ui12   = {20'b0, inst_i[21:10]};
    assign si20   = {inst_i[24:5], 12'b0};
    assign offs16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b0};
    assign offs26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b0};

    // Zero pc is let through
    assign adef = (pc_i != '0) && ((pc_i < FETCH_LO) || (pc_i > FETCH_HI));

    always_comb begin
        dec = '0;
        hit = 1'b1;
        casez (inst_i[31:15])
            17'b00000000000100000: dec.op = OP_ADD;
            17'b00000000000100010: dec.op = OP_SUB;
            17'b00000000000101001: dec.op = OP_AND;
            17'b00000000000101010: dec.op = OP_OR;
            17'b00000000000101011: dec.op = OP_XOR;
            17'b0000001010???????: dec.op = OP_ADD;
            17'b0000001110???????: dec.op = OP_OR;
            17'b0001010??????????: dec.op = OP_LUI;
            17'b0010100010???????: dec.op = OP_LD;
            17'b0010100110???????: dec.op = OP_ST;
            17'b010110???????????: dec.op = OP_BEQ;
            17'b010111???????????: dec.op = OP_BNE;
            17'b010100???????????: dec.op = OP_B;
            17'b010101???????????: dec.op = OP_BL;
            default:               hit = 1'b0;
        endcase

        // 3R forms carry rk, 2RI12 forms carry an immediate
        if (inst_i[31:20] == 12'h001) begin
            dec.unit      = UNIT_ALU;
            dec.rd        = rd_f;
            dec.rj        = rj_f;
            dec.rk        = rk_f;
            dec.reg_write = 1'b1;
        end else begin
            case (dec.op)
                OP_ADD: begin
                    dec.unit      = UNIT_ALU;
                    dec.rd        = rd_f;
                    dec.rj        = rj_f;
                    dec.imm       = si12;
                    dec.reg_write = 1'b1;
                end
                OP_OR: begin
                    dec.unit      = UNIT_ALU;
                    dec.rd        = rd_f;
                    dec.rj        = rj_f;
                    dec.imm       = ui12;
                    dec.reg_write = 1'b1;
                end
                OP_LUI: begin
                    dec.unit      = UNIT_ALU;
                    dec.rd        = rd_f;
                    dec.imm       = si20;
                    dec.reg_write = 1'b1;
                end
                OP_LD: begin
                    dec.unit      = UNIT_LSU;
                    dec.rd        = rd_f;
                    dec.rj        = rj_f;
                    dec.imm       = si12;
                    dec.reg_write = 1'b1;
                end
                // Store data register goes out as the second source
                OP_ST: begin
                    dec.unit = UNIT_LSU;
                    dec.rj   = rj_f;
                    dec.rk   = rd_f;
                    dec.imm  = si12;
                end
                OP_BEQ, OP_BNE: begin
                    dec.unit = UNIT_BRU;
                    dec.rj   = rj_f;
                    dec.rk   = rd_f;
                    dec.imm  = offs16;
                end
                OP_B: begin
                    dec.unit = UNIT_BRU;
                    dec.imm  = offs26;
                end
                OP_BL: begin
                    dec.unit      = UNIT_BRU;
                    dec.rd        = 5'd1;
                    dec.imm       = offs26;
                    dec.reg_write = 1'b1;
                end
                default: dec.unit = UNIT_ALU;
            endcase
        end
    end

    always_comb begin
        rec_o           = (adef || !hit) ? '0 : dec;
        rec_o.pc        = pc_i;
        rec_o.pre_taken = pre_taken_i;
        rec_o.pre_addr  = pre_addr_i;
        rec_o.exc.adef  = adef;
        rec_o.exc.ine   = !adef && !hit;
    end

endmodule

//--- design/decoder.sv
module decoder
    import core_cfg_pkg::*;
    import decode_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic [DECODER_WIDTH-1:0] fetch_valid_i,
    input  bus32_t [DECODER_WIDTH-1:0] fetch_pc_i,
    input  bus32_t [DECODER_WIDTH-1:0] fetch_inst_i,
    input  logic [DECODER_WIDTH-1:0] pre_taken_i,
    input  bus32_t [DECODER_WIDTH-1:0] pre_addr_i,
    iq_if.producer                   iq,
    output logic                     stall_o
);

    id_dispatch_t [DECODER_WIDTH-1:0] lane_rec;
    logic out_of_reset;

    for (genvar i = 0; i < DECODER_WIDTH; i++) begin : g_lane
        inst_decoder u_inst_decoder (
            .pc_i        (fetch_pc_i[i]),
            .inst_i      (fetch_inst_i[i]),
            .pre_taken_i (pre_taken_i[i]),
            .pre_addr_i  (pre_addr_i[i]),
            .rec_o       (lane_rec[i])
        );
    end

    // Hold fetch off until the first edge after reset release
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    // Pack valid lanes toward entry 0, keeping program order
    always_comb begin
        iq.enq_data = lane_rec;
        iq.enq_en   = '0;
        if (fetch_valid_i[0]) begin
            iq.enq_en = fetch_valid_i[1] ? 2'b11 : 2'b01;
        end else if (fetch_valid_i[1]) begin
            iq.enq_data[0] = lane_rec[1];
            iq.enq_en      = 2'b01;
        end
        if (iq.full || !out_of_reset) begin
            iq.enq_en = '0;
        end
    end

    assign stall_o = iq.full || !out_of_reset;

endmodule

//--- design/issue_queue.sv
module issue_queue
    import core_cfg_pkg::*;
#(
    parameter type entry_t = logic
) (
    input logic   clk_i,
    input logic   arst_n_i,
    input logic   flush_i,
    iq_if.buffer  iq
);

    typedef logic [IQ_PTR_W-1:0] ptr_t;
    typedef logic [IQ_PTR_W:0]   cnt_t;

    entry_t mem [IQ_DEPTH];

    ptr_t head;
    ptr_t tail;
    cnt_t count;
    logic [1:0] n_enq;
    logic [1:0] n_deq;

    assign n_enq = 2'($countones(iq.enq_en));
    assign n_deq = 2'($countones(iq.deq_en));

    // Storage, up to two writes per edge starting at tail
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < DECODER_WIDTH; i++) begin
            if (iq.enq_en[i] && !flush_i) begin
                mem[tail + ptr_t'(i)] <= iq.enq_data[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_t'(n_deq);
            tail  <= tail + ptr_t'(n_enq);
            count <= count + cnt_t'(n_enq) - cnt_t'(n_deq);
        end
    end

    // Oldest entries always on the read ports
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_rd
        assign iq.deq_data[i] = mem[head + ptr_t'(i)];
    end

    assign iq.count = count;

    // Full as soon as a two-wide write could overflow
    assign iq.full = count > cnt_t'(IQ_DEPTH - 2);

endmodule

//--- design/dispatch_unit.sv
module dispatch_unit
    import core_cfg_pkg::*;
    import decode_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         flush_i,
    input  logic                         issue_stall_i,
    iq_if.consumer                       iq,
    output logic [ISSUE_WIDTH-1:0]       issue_valid_o,
    output id_dispatch_t [ISSUE_WIDTH-1:0] issue_rec_o
);

    logic pop0;
    logic pop1;
    logic lsu_pair;
    logic head_bru;

    assign lsu_pair = (iq.deq_data[0].unit == UNIT_LSU) && (iq.deq_data[1].unit == UNIT_LSU);
    assign head_bru = iq.deq_data[0].unit == UNIT_BRU;

    assign pop0 = (iq.count != '0) && !issue_stall_i && !flush_i;

    // Second slot only pairs with a non-branch head and never two memory ops
    assign pop1 = pop0 && (iq.count >= 2) && !lsu_pair && !head_bru;

    assign iq.deq_en = {pop1, pop0};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue_valid_o <= '0;
        end else if (flush_i) begin
            issue_valid_o <= '0;
        end else begin
            issue_valid_o <= iq.deq_en;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (iq.deq_en[i]) begin
                issue_rec_o[i] <= iq.deq_data[i];
            end
        end
    end

endmodule

//--- design/decoder_top.sv
module decoder_top
    import core_cfg_pkg::*;
    import decode_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           flush_i,
    input  logic   [DECODER_WIDTH-1:0]     fetch_valid_i,
    input  bus32_t [DECODER_WIDTH-1:0]     fetch_pc_i,
    input  bus32_t [DECODER_WIDTH-1:0]     fetch_inst_i,
    input  logic   [DECODER_WIDTH-1:0]     pre_taken_i,
    input  bus32_t [DECODER_WIDTH-1:0]     pre_addr_i,
    output logic                           stall_o,
    input  logic                           issue_stall_i,
    output logic   [ISSUE_WIDTH-1:0]       issue_valid_o,
    output bus32_t [ISSUE_WIDTH-1:0]       issue_pc_o,
    output unit_t  [ISSUE_WIDTH-1:0]       issue_unit_o,
    output op_t    [ISSUE_WIDTH-1:0]       issue_op_o,
    output logic   [ISSUE_WIDTH-1:0][4:0]  issue_rd_o,
    output logic   [ISSUE_WIDTH-1:0][4:0]  issue_rj_o,
    output logic   [ISSUE_WIDTH-1:0][4:0]  issue_rk_o,
    output bus32_t [ISSUE_WIDTH-1:0]       issue_imm_o,
    output logic   [ISSUE_WIDTH-1:0]       issue_reg_write_o,
    output exc_t   [ISSUE_WIDTH-1:0]       issue_exc_o
);

    id_dispatch_t [ISSUE_WIDTH-1:0] issue_rec;

    iq_if iq ();

    decoder u_decoder (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_inst_i  (fetch_inst_i),
        .pre_taken_i   (pre_taken_i),
        .pre_addr_i    (pre_addr_i),
        .iq            (iq.producer),
        .stall_o       (stall_o)
    );

    issue_queue #(
        .entry_t (id_dispatch_t)
    ) u_issue_queue (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .iq       (iq.buffer)
    );

    dispatch_unit u_dispatch_unit (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .issue_stall_i (issue_stall_i),
        .iq            (iq.consumer),
        .issue_valid_o (issue_valid_o),
        .issue_rec_o   (issue_rec)
    );

    // Flatten the issue records onto plain ports
    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_issue
        assign issue_pc_o[i]        = issue_rec[i].pc;
        assign issue_unit_o[i]      = issue_rec[i].unit;
        assign issue_op_o[i]        = issue_rec[i].op;
        assign issue_rd_o[i]        = issue_rec[i].rd;
        assign issue_rj_o[i]        = issue_rec[i].rj;
        assign issue_rk_o[i]        = issue_rec[i].rk;
        assign issue_imm_o[i]       = issue_rec[i].imm;
        assign issue_reg_write_o[i] = issue_rec[i].reg_write;
        assign issue_exc_o[i]       = issue_rec[i].exc;
    end

endmodule

//--- bench/decoder_top_assertions.sv
module decoder_top_assertions
    import core_cfg_pkg::*;
    import decode_pkg::*;
(
    input logic                           clk_i,
    input logic                           arst_n_i,
    input logic                           flush_i,
    input logic                           issue_stall_i,
    input logic         [ISSUE_WIDTH-1:0] issue_valid_i,
    input id_dispatch_t [ISSUE_WIDTH-1:0] issue_rec_i
);

    // Slot 1 is the younger record and never goes out alone
    slot1_with_slot0: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        issue_valid_i[1] |-> issue_valid_i[0])
        else $error("slot 1 issued without slot 0");

    no_lsu_pair: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (issue_valid_i == 2'b11) |->
            !((issue_rec_i[0].unit == UNIT_LSU) && (issue_rec_i[1].unit == UNIT_LSU)))
        else $error("two LSU records in one issue pair");

    bru_alone: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (issue_valid_i == 2'b11) |-> (issue_rec_i[0].unit != UNIT_BRU))
        else $error("BRU head issued together with a second record");

    // Nothing leaves the cycle after a flush or an issue stall
    quiet_after_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (flush_i || issue_stall_i) |=> (issue_valid_i == '0))
        else $error("issue after flush or issue stall");

endmodule

//--- bench/decoder_top_tb.sv
module decoder_top_tb
    import core_cfg_pkg::*;
    import decode_pkg::*;
();

    logic clk_i = 1'b0;
    logic arst_n_i;
    logic flush_i;
    logic   [DECODER_WIDTH-1:0] fetch_valid_i;
    bus32_t [DECODER_WIDTH-1:0] fetch_pc_i;
    bus32_t [DECODER_WIDTH-1:0] fetch_inst_i;
    logic   [DECODER_WIDTH-1:0] pre_taken_i;
    bus32_t [DECODER_WIDTH-1:0] pre_addr_i;
    logic stall_o;
    logic issue_stall_i;
    logic   [ISSUE_WIDTH-1:0]      issue_valid_o;
    bus32_t [ISSUE_WIDTH-1:0]      issue_pc_o;
    unit_t  [ISSUE_WIDTH-1:0]      issue_unit_o;
    op_t    [ISSUE_WIDTH-1:0]      issue_op_o;
    logic   [ISSUE_WIDTH-1:0][4:0] issue_rd_o;
    logic   [ISSUE_WIDTH-1:0][4:0] issue_rj_o;
    logic   [ISSUE_WIDTH-1:0][4:0] issue_rk_o;
    bus32_t [ISSUE_WIDTH-1:0]      issue_imm_o;
    logic   [ISSUE_WIDTH-1:0]      issue_reg_write_o;
    exc_t   [ISSUE_WIDTH-1:0]      issue_exc_o;

    // Records accepted by fetch and not yet issued, oldest first
    id_dispatch_t exp_q[$];
    logic last_flush;
    logic last_stall;
    logic [ISSUE_WIDTH-1:0] exp_valid;

    decoder_top i_dut (.*);

    bind dispatch_unit decoder_top_assertions i_assertions (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .flush_i       (flush_i),
        .issue_stall_i (issue_stall_i),
        .issue_valid_i (issue_valid_o),
        .issue_rec_i   (issue_rec_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input bus32_t exp, input bus32_t act);
        if (exp !== act) abort_run($sformatf("Error %s expected %h actual %h", name, exp, act));
    endtask

    task automatic compare_unit(input string name, input unit_t exp, input unit_t act);
        if (exp !== act) abort_run($sformatf("Error %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic compare_op(input string name, input op_t exp, input op_t act);
        if (exp !== act) abort_run($sformatf("Error %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic compare_exc(input string name, input exc_t exp, input exc_t act);
        if (exp !== act) abort_run($sformatf("Error %s expected %b actual %b", name, exp, act));
    endtask

    task automatic compare_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (exp !== act) abort_run($sformatf("Error %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) abort_run($sformatf("Error %s expected %b actual %b", name, exp, act));
    endtask

    function automatic id_dispatch_t pack_fields(unit_t u, op_t o, logic [4:0] rd, logic [4:0] rj,
                                                 logic [4:0] rk, bus32_t imm, logic wr);
        id_dispatch_t r;
        r = '0;
        r.unit = u;
        r.op = o;
        r.rd = rd;
        r.rj = rj;
        r.rk = rk;
        r.imm = imm;
        r.reg_write = wr;
        return r;
    endfunction

    // Reference decode from the instruction set encodings
    function automatic id_dispatch_t ref_decode(bus32_t pc, bus32_t inst, logic taken,
                                                bus32_t target);
        id_dispatch_t r;
        bus32_t si12;
        bus32_t offs16;
        bus32_t offs26;
        logic known;
        logic adef;
        si12 = 32'(signed'(inst[21:10]));
        offs16 = 32'(signed'({inst[25:10], 2'b00}));
        offs26 = 32'(signed'({inst[9:0], inst[25:10], 2'b00}));
        known = 1'b1;
        r = '0;
        case (1'b1)
            inst[31:15] == 17'h00020: r = pack_fields(UNIT_ALU, OP_ADD, inst[4:0], inst[9:5],
                                                      inst[14:10], '0, 1'b1);
            inst[31:15] == 17'h00022: r = pack_fields(UNIT_ALU, OP_SUB, inst[4:0], inst[9:5],
                                                      inst[14:10], '0, 1'b1);
            inst[31:15] == 17'h00029: r = pack_fields(UNIT_ALU, OP_AND, inst[4:0], inst[9:5],
                                                      inst[14:10], '0, 1'b1);
            inst[31:15] == 17'h0002a: r = pack_fields(UNIT_ALU, OP_OR, inst[4:0], inst[9:5],
                                                      inst[14:10], '0, 1'b1);
            inst[31:15] == 17'h0002b: r = pack_fields(UNIT_ALU, OP_XOR, inst[4:0], inst[9:5],
                                                      inst[14:10], '0, 1'b1);
            inst[31:22] == 10'h00a: r = pack_fields(UNIT_ALU, OP_ADD, inst[4:0], inst[9:5], 5'd0,
                                                    si12, 1'b1);
            inst[31:22] == 10'h00e: r = pack_fields(UNIT_ALU, OP_OR, inst[4:0], inst[9:5], 5'd0,
                                                    {20'd0, inst[21:10]}, 1'b1);
            inst[31:25] == 7'h0a: r = pack_fields(UNIT_ALU, OP_LUI, inst[4:0], 5'd0, 5'd0,
                                                  {inst[24:5], 12'd0}, 1'b1);
            inst[31:22] == 10'h0a2: r = pack_fields(UNIT_LSU, OP_LD, inst[4:0], inst[9:5], 5'd0,
                                                    si12, 1'b1);
            inst[31:22] == 10'h0a6: r = pack_fields(UNIT_LSU, OP_ST, 5'd0, inst[9:5], inst[4:0],
                                                    si12, 1'b0);
            inst[31:26] == 6'h16: r = pack_fields(UNIT_BRU, OP_BEQ, 5'd0, inst[9:5], inst[4:0],
                                                  offs16, 1'b0);
            inst[31:26] == 6'h17: r = pack_fields(UNIT_BRU, OP_BNE, 5'd0, inst[9:5], inst[4:0],
                                                  offs16, 1'b0);
            inst[31:26] == 6'h14: r = pack_fields(UNIT_BRU, OP_B, 5'd0, 5'd0, 5'd0, offs26, 1'b0);
            inst[31:26] == 6'h15: r = pack_fields(UNIT_BRU, OP_BL, 5'd1, 5'd0, 5'd0, offs26, 1'b1);
            default: known = 1'b0;
        endcase
        adef = (pc != '0) && ((pc < 32'h1c00_0000) || (pc > 32'h1fff_ffff));
        if (adef || !known) r = '0;
        r.pc = pc;
        r.pre_taken = taken;
        r.pre_addr = target;
        r.exc.adef = adef;
        r.exc.ine = !adef && !known;
        return r;
    endfunction

    function automatic bus32_t gen_pc();
        int unsigned pick;
        pick = $urandom_range(0, 15);
        if (pick == 0) return '0;
        if (pick == 1) return $urandom;
        return 32'h1c00_0000 | ($urandom & 32'h03ff_fffc);
    endfunction

    // Mostly legal encodings with random fields, some random words
    function automatic bus32_t gen_inst();
        bus32_t w;
        w = $urandom;
        case ($urandom_range(0, 15))
            0: return {17'h00020, w[14:0]};
            1: return {17'h00022, w[14:0]};
            2: return {17'h00029, w[14:0]};
            3: return {17'h0002a, w[14:0]};
            4: return {17'h0002b, w[14:0]};
            5: return {10'h00a, w[21:0]};
            6: return {10'h00e, w[21:0]};
            7: return {7'h0a, w[24:0]};
            8: return {10'h0a2, w[21:0]};
            9: return {10'h0a6, w[21:0]};
            10: return {6'h16, w[25:0]};
            11: return {6'h17, w[25:0]};
            12: return {6'h14, w[25:0]};
            13: return {6'h15, w[25:0]};
            default: return w;
        endcase
    endfunction

    task automatic drive_lanes(input bit active);
        for (int l = 0; l < DECODER_WIDTH; l++) begin
            fetch_valid_i[l] = active && ($urandom_range(0, 3) != 0);
            fetch_pc_i[l] = gen_pc();
            fetch_inst_i[l] = gen_inst();
            pre_taken_i[l] = 1'($urandom_range(0, 1));
            pre_addr_i[l] = $urandom;
        end
    endtask

    task automatic accept_lanes();
        for (int l = 0; l < DECODER_WIDTH; l++) begin
            if (fetch_valid_i[l]) begin
                exp_q.push_back(ref_decode(fetch_pc_i[l], fetch_inst_i[l], pre_taken_i[l],
                                           pre_addr_i[l]));
            end
        end
    endtask

    task automatic check_issue();
        id_dispatch_t e;
        string tag;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            tag = $sformatf("slot%0d", s);
            compare_flag({tag, " valid"}, exp_valid[s], issue_valid_o[s]);
            if (issue_valid_o[s]) begin
                e = exp_q.pop_front();
                compare_word({tag, " pc"}, e.pc, issue_pc_o[s]);
                compare_exc({tag, " exc"}, e.exc, issue_exc_o[s]);
                compare_unit({tag, " unit"}, e.unit, issue_unit_o[s]);
                compare_op({tag, " op"}, e.op, issue_op_o[s]);
                compare_reg({tag, " rd"}, e.rd, issue_rd_o[s]);
                compare_reg({tag, " rj"}, e.rj, issue_rj_o[s]);
                compare_reg({tag, " rk"}, e.rk, issue_rk_o[s]);
                compare_word({tag, " imm"}, e.imm, issue_imm_o[s]);
                compare_flag({tag, " reg_write"}, e.reg_write, issue_reg_write_o[s]);
            end
        end
    endtask

    // One falling edge: check issue, account for the last drive, drive again
    task automatic run_cycle(input bit active);
        @(negedge clk_i);
        check_issue();
        if (last_flush) begin
            exp_q.delete();
        end else if (!last_stall) begin
            accept_lanes();
        end
        // Full once fewer than two entries are free
        compare_flag("stall_o", exp_q.size() > IQ_DEPTH - 2, stall_o);
        // Lanes refused under stall stay on the bus
        if (last_flush || !last_stall) drive_lanes(active);
        flush_i = active && ($urandom_range(0, 39) == 0);
        issue_stall_i = active && ($urandom_range(0, 3) == 0);
        last_flush = flush_i;
        last_stall = stall_o;
        // Expected issue at the next edge from the queue contents and the pairing rule
        exp_valid = '0;
        if (!flush_i && !issue_stall_i && (exp_q.size() != 0)) begin
            exp_valid[0] = 1'b1;
            if ((exp_q.size() > 1) && (exp_q[0].unit != UNIT_BRU) &&
                !((exp_q[0].unit == UNIT_LSU) && (exp_q[1].unit == UNIT_LSU))) begin
                exp_valid[1] = 1'b1;
            end
        end
    endtask

    initial begin
        int unsigned wait_cnt;
        void'($urandom(10328));
        arst_n_i = 1'b0;
        flush_i = 1'b0;
        issue_stall_i = 1'b0;
        fetch_valid_i = '0;
        fetch_pc_i = '0;
        fetch_inst_i = '0;
        pre_taken_i = '0;
        pre_addr_i = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        wait_cnt = 0;
        while (stall_o) begin
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > 10) abort_run("stall_o stayed high after reset");
        end
        compare_flag("reset issue_valid", 1'b0, |issue_valid_o);
        last_flush = 1'b0;
        last_stall = 1'b0;
        exp_valid = '0;
        for (int n = 0; n < 3000; n++) run_cycle(1'b1);
        wait_cnt = 0;
        while ((exp_q.size() != 0) || (fetch_valid_i != '0)) begin
            run_cycle(1'b0);
            wait_cnt++;
            if (wait_cnt > 200) abort_run("timeout while draining the issue queue");
        end
        repeat (4) run_cycle(1'b0);
        if (exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run("records were still expected at the end of the run");
        end
    end

endmodule

//--- decoder_top.f
design/core_cfg_pkg.sv
design/decode_pkg.sv
design/iq_if.sv
design/inst_decoder.sv
design/decoder.sv
design/issue_queue.sv
design/dispatch_unit.sv
design/decoder_top.sv
bench/decoder_top_assertions.sv
bench/decoder_top_tb.sv

//--- Makefile
TOP = decoder_top_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f decoder_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f decoder_top.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
